//--- rv_pipe_defs.svh
`ifndef RV_PIPE_DEFS_SVH
`define RV_PIPE_DEFS_SVH

// Build options for the pipeline control subsystem
// Every option is a plain value so that it can be tested in generate blocks

// Set to 1 when an external forwarding unit feeds operands back to ID and EX
// With it, only producers whose result is not yet available cause a stall
// Set to 0 to stall on every RAW dependency still in flight
`define RV_FWD 1

// Set to 1 when the register file passes a same-cycle write through to its read port
// In that case an instruction in WB never blocks a reader in ID
`define RV_FWD_REGFILE 1

// Data memory flavours
// With SRAM the load data is valid in MEM and can be forwarded from there
// With BRAM the read takes a full cycle and the data only shows up in WB
`define RV_MEM_TYPE_SRAM 0
`define RV_MEM_TYPE_BRAM 1

// Memory flavour used by this build
`define RV_MEM_TYPE `RV_MEM_TYPE_BRAM

// Number of cycles a divide-class operation keeps EX busy
// Must be 2 or more, the sequencer counter is sized from it
`define RV_MDU_CYCLES 4

`endif

//--- rv_pipe_pkg.sv
package rv_pipe_pkg;

  // Architectural register number, x0 reads as zero and is never a real target
  typedef logic [4:0] reg_addr_t;

  // Where the write-back value of an instruction comes from
  typedef logic [2:0] res_src_t;

  // Plain ALU result, ready at the end of EX
  localparam res_src_t RES_ALU  = 3'd0;
  // Data memory read
  localparam res_src_t RES_LOAD = 3'd1;
  // CSR read value, only valid in WB
  localparam res_src_t RES_CSR  = 3'd2;
  // Multiply or divide unit result
  localparam res_src_t RES_M    = 3'd3;
  // Link address for JAL and JALR
  localparam res_src_t RES_PC4  = 3'd4;

  // Source of the next fetch address
  typedef logic [1:0] pc_sel_t;

  // Fall through to PC + 4
  localparam pc_sel_t PC_SEL_SEQ       = 2'd0;
  // Predicted target from the BTB, the RAS or static decode in ID
  localparam pc_sel_t PC_SEL_PREDICTED = 2'd1;
  // Resolved branch or jump target coming back from EX
  localparam pc_sel_t PC_SEL_REDIRECT  = 2'd2;

  // States of the multi-cycle sequencer
  // IDLE waits for a divide-class op in EX
  // BUSY counts the remaining execution cycles
  // DONE is the single cycle in which the op is allowed to leave EX
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    DONE = 2'd2
  } mdu_state_t;

endpackage

//--- rv_ctrl_stage.sv
`timescale 1ns/10ps

// One pipeline register for the destination side of an instruction
// It carries the target register, its write enable, the result source
// and the multi-cycle marker from one stage to the next
module rv_ctrl_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  stall,
  input  logic                  flush,
  input  rv_pipe_pkg::reg_addr_t rd,
  input  logic                  reg_write,
  input  rv_pipe_pkg::res_src_t  res_src,
  input  logic                  multi,
  output rv_pipe_pkg::reg_addr_t rd_q,
  output logic                  reg_write_q,
  output rv_pipe_pkg::res_src_t  res_src_q,
  output logic                  multi_q
);

  // A bubble is loaded on reset and on a flush that is not overridden by a stall
  // Stall wins over flush so that an op frozen in EX is never thrown away
  logic load_bubble;

  assign load_bubble = rst || (flush && !stall);

  always_ff @(posedge clk) begin
    if (load_bubble) begin
      // Bubble looks like a NOP writing nothing to x0
      rd_q        <= '0;
      reg_write_q <= 1'b0;
      res_src_q   <= rv_pipe_pkg::RES_ALU;
      multi_q     <= 1'b0;
    end else if (!stall) begin
      rd_q        <= rd;
      reg_write_q <= reg_write;
      res_src_q   <= res_src;
      multi_q     <= multi;
    end
    // Otherwise the stage holds what it has
  end

  // After a flush that took effect the stage must not write the register file
  a_flush_kills_write: assert property (
    @(posedge clk) disable iff (rst)
    (flush && !stall) |=> !reg_write_q
  ) else $error("rv_ctrl_stage: write enable survived a flush");

endmodule

//--- rv_mdu_seq.sv
`timescale 1ns/10ps

`include "rv_pipe_defs.svh"

// Sequencer for divide-class operations sitting in EX
// It keeps op_active_ex high for RV_MDU_CYCLES cycles in a row, starting in
// the first cycle the op shows up at the ID/EX output, and then drops it for
// one cycle so that the finished op moves on to MEM
module rv_mdu_seq (
  input  logic clk,
  input  logic rst,
  input  logic multi_ex,
  output logic op_active_ex
);

  // Counter only needs to hold RV_MDU_CYCLES - 1
  localparam int CNT_W = $clog2(`RV_MDU_CYCLES);

  rv_pipe_pkg::mdu_state_t state;
  logic [CNT_W-1:0]        cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rv_pipe_pkg::IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        rv_pipe_pkg::IDLE: begin
          // The IDLE cycle already counts as the first busy cycle
          if (multi_ex) begin
            state <= rv_pipe_pkg::BUSY;
            cnt   <= CNT_W'(`RV_MDU_CYCLES - 1);
          end
        end
        rv_pipe_pkg::BUSY: begin
          cnt <= cnt - CNT_W'(1);
          // On the last busy cycle the op is released at the following edge
          if (cnt == CNT_W'(1)) begin
            state <= rv_pipe_pkg::DONE;
          end
        end
        rv_pipe_pkg::DONE: begin
          // The finished op still shows multi_ex here, so it is ignored
          state <= rv_pipe_pkg::IDLE;
        end
        default: begin
          state <= rv_pipe_pkg::IDLE;
          cnt   <= '0;
        end
      endcase
    end
  end

  // Busy level goes straight to the hazard unit without a register in between
  assign op_active_ex = ((state == rv_pipe_pkg::IDLE) && multi_ex) ||
                        ((state == rv_pipe_pkg::BUSY) && (cnt != '0));

  // Counter never reaches the full cycle count
  a_cnt_bounded: assert property (
    @(posedge clk) disable iff (rst)
    int'(cnt) < `RV_MDU_CYCLES
  ) else $error("rv_mdu_seq: counter out of range");

endmodule

//--- rv_hazard.sv
`timescale 1ns/10ps

`include "rv_pipe_defs.svh"

// Data and control hazard detection for the five-stage pipe
//
// RAW dependencies between the registers read in ID and the destinations in
// EX, MEM and WB either stall the front end and push a bubble into EX, or,
// while a multi-cycle op is running, freeze the whole pipe instead.
// Redirects and mispredictions flush the two youngest stages and take
// priority over any data stall, since the stalled instruction is discarded.
//
// Purely combinational, all outputs follow their inputs in the same cycle.
module rv_hazard (
  // Source registers of the instruction in ID
  input  rv_pipe_pkg::reg_addr_t rs1_id,
  input  rv_pipe_pkg::reg_addr_t rs2_id,
  input  logic                  rs1_used_id,
  input  logic                  rs2_used_id,

  // Destination of the instruction in EX
  input  rv_pipe_pkg::reg_addr_t rd_ex,
  input  logic                  reg_write_ex,
  input  rv_pipe_pkg::res_src_t  res_src_ex,
  input  logic                  op_active_ex,

  // Destination of the instruction in MEM
  input  rv_pipe_pkg::reg_addr_t rd_mem,
  input  logic                  reg_write_mem,
  input  rv_pipe_pkg::res_src_t  res_src_mem,

  // Destination of the instruction in WB
  input  rv_pipe_pkg::reg_addr_t rd_wb,
  input  logic                  reg_write_wb,

  // Fetch steering and prediction status
  input  rv_pipe_pkg::pc_sel_t   pc_sel,
  input  logic                  mispredicted_ex,
  input  logic                  jalr_mispredicted_mem,
  // BTB and RAS hits are IF-aligned, they qualify the current PC_SEL_PREDICTED
  input  logic                  btb_pred_taken,
  input  logic                  ras_pred_taken,

  output logic                  pc_stall,
  output logic                  if_id_stall,
  output logic                  if_id_flush,
  output logic                  id_ex_stall,
  output logic                  id_ex_flush,
  output logic                  ex_mem_stall,
  output logic                  mem_wb_stall
);

  // True when a writer to rd feeds one of the sources read in ID
  // Writes to x0 are dropped by the register file and never count
  function automatic logic reads_from(input rv_pipe_pkg::reg_addr_t rd,
                                      input logic                  we);
    logic hit1;
    logic hit2;
    hit1 = rs1_used_id && (rs1_id == rd);
    hit2 = rs2_used_id && (rs2_id == rd);
    return we && (rd != '0) && (hit1 || hit2);
  endfunction

  logic ex_hit;
  logic mem_hit;
  logic wb_hit;

  always_comb begin
    ex_hit  = reads_from(rd_ex, reg_write_ex);
    mem_hit = reads_from(rd_mem, reg_write_mem);
    // WB only matters when the register file cannot pass its write through
    wb_hit  = (`RV_FWD_REGFILE == 0) && reads_from(rd_wb, reg_write_wb);
  end

  // Producers whose value is not ready for forwarding back to ID yet
  logic late_ex;
  logic late_mem;

  if (`RV_MEM_TYPE == `RV_MEM_TYPE_BRAM) begin : g_bram
    // BRAM load data only arrives in WB, so loads block in EX and in MEM
    assign late_ex  = (res_src_ex == rv_pipe_pkg::RES_LOAD) ||
                      (res_src_ex == rv_pipe_pkg::RES_CSR) ||
                      (res_src_ex == rv_pipe_pkg::RES_M);
    assign late_mem = (res_src_mem == rv_pipe_pkg::RES_LOAD) ||
                      (res_src_mem == rv_pipe_pkg::RES_CSR) ||
                      (res_src_mem == rv_pipe_pkg::RES_M);
  end else begin : g_sram
    // SRAM load data can be forwarded from MEM, only CSR and M results wait
    assign late_ex  = (res_src_ex == rv_pipe_pkg::RES_CSR) ||
                      (res_src_ex == rv_pipe_pkg::RES_M);
    assign late_mem = (res_src_mem == rv_pipe_pkg::RES_CSR) ||
                      (res_src_mem == rv_pipe_pkg::RES_M);
  end

  logic data_hazard;

  if (`RV_FWD != 0) begin : g_fwd
    // Ordinary EX and MEM results are covered by the forwarding unit
    assign data_hazard = (ex_hit && late_ex) || (mem_hit && late_mem) || wb_hit;
  end else begin : g_no_fwd
    // Without forwarding every pending writer holds the reader in ID
    assign data_hazard = ex_hit || mem_hit || wb_hit;
  end

  logic pc_redirect;
  logic pc_predicted;
  logic redirect_any;
  logic front_hold;
  logic pred_flush;

  assign pc_redirect  = (pc_sel == rv_pipe_pkg::PC_SEL_REDIRECT);
  assign pc_predicted = (pc_sel == rv_pipe_pkg::PC_SEL_PREDICTED);

  // Any of these throws away the instructions in IF/ID and ID/EX
  assign redirect_any = pc_redirect || mispredicted_ex || jalr_mispredicted_mem;

  // Front end waits on a data hazard or on a running multi-cycle op
  assign front_hold = data_hazard || op_active_ex;

  // A BTB hit redirects fetch early enough that nothing wrong was fetched
  // RAS and static predictions come from ID, so the sequential fetch must go
  // The flush only applies while ID actually advances
  assign pred_flush = pc_predicted && (!btb_pred_taken || ras_pred_taken) && !front_hold;

  assign pc_stall    = front_hold && !redirect_any;
  assign if_id_stall = front_hold && !redirect_any;
  assign if_id_flush = redirect_any || pred_flush;

  // ID/EX takes a bubble on a data hazard, but is frozen under a multi-cycle op
  assign id_ex_stall = op_active_ex;
  assign id_ex_flush = (data_hazard && !op_active_ex) || redirect_any;

  // Back half of the pipe only stops for the multi-cycle op
  assign ex_mem_stall = op_active_ex;
  assign mem_wb_stall = op_active_ex;

  // Holding and discarding IF/ID at once would lose the decoded instruction
  always_comb begin
    a_if_id_excl: assert final (!(if_id_stall && if_id_flush))
      else $error("rv_hazard: IF/ID stalled and flushed together");
  end

endmodule

//--- rv_pipe_ctrl.sv
`timescale 1ns/10ps

// Pipeline control subsystem
// Carries destination metadata from ID to WB, tracks multi-cycle ops in EX
// and produces the stall and flush controls for every pipeline register
module rv_pipe_ctrl (
  input  logic                  clk,
  input  logic                  rst,

  // Decoded instruction in ID
  input  rv_pipe_pkg::reg_addr_t id_rs1,
  input  rv_pipe_pkg::reg_addr_t id_rs2,
  input  rv_pipe_pkg::reg_addr_t id_rd,
  input  logic                  id_rs1_used,
  input  logic                  id_rs2_used,
  input  logic                  id_reg_write,
  input  rv_pipe_pkg::res_src_t  id_res_src,
  input  logic                  id_multi,

  // Fetch steering and prediction status
  input  rv_pipe_pkg::pc_sel_t   pc_sel,
  input  logic                  mispredicted_ex,
  input  logic                  jalr_mispredicted_mem,
  input  logic                  btb_pred_taken,
  input  logic                  ras_pred_taken,

  output logic                  pc_stall,
  output logic                  if_id_stall,
  output logic                  if_id_flush,
  output logic                  id_ex_stall,
  output logic                  id_ex_flush,
  output logic                  ex_mem_stall,
  output logic                  mem_wb_stall,

  // Register file write port control
  output rv_pipe_pkg::reg_addr_t wb_rd,
  output logic                  wb_reg_write
);

  // EX stage metadata
  rv_pipe_pkg::reg_addr_t ex_rd;
  logic                   ex_reg_write;
  rv_pipe_pkg::res_src_t  ex_res_src;
  logic                   ex_multi;

  // MEM stage metadata
  rv_pipe_pkg::reg_addr_t mem_rd;
  logic                   mem_reg_write;
  rv_pipe_pkg::res_src_t  mem_res_src;
  logic                   mem_multi;

  logic                   op_active_ex;

  rv_ctrl_stage u_id_ex (
    .clk         (clk),
    .rst         (rst),
    .stall       (id_ex_stall),
    .flush       (id_ex_flush),
    .rd          (id_rd),
    .reg_write   (id_reg_write),
    .res_src     (id_res_src),
    .multi       (id_multi),
    .rd_q        (ex_rd),
    .reg_write_q (ex_reg_write),
    .res_src_q   (ex_res_src),
    .multi_q     (ex_multi)
  );

  // EX/MEM and MEM/WB are never flushed, a redirect only hits the young stages
  rv_ctrl_stage u_ex_mem (
    .clk         (clk),
    .rst         (rst),
    .stall       (ex_mem_stall),
    .flush       (1'b0),
    .rd          (ex_rd),
    .reg_write   (ex_reg_write),
    .res_src     (ex_res_src),
    .multi       (ex_multi),
    .rd_q        (mem_rd),
    .reg_write_q (mem_reg_write),
    .res_src_q   (mem_res_src),
    .multi_q     (mem_multi)
  );

  // Only the write target and enable are needed past WB
  rv_ctrl_stage u_mem_wb (
    .clk         (clk),
    .rst         (rst),
    .stall       (mem_wb_stall),
    .flush       (1'b0),
    .rd          (mem_rd),
    .reg_write   (mem_reg_write),
    .res_src     (mem_res_src),
    .multi       (mem_multi),
    .rd_q        (wb_rd),
    .reg_write_q (wb_reg_write),
    .res_src_q   (),
    .multi_q     ()
  );

  rv_mdu_seq u_mdu_seq (
    .clk          (clk),
    .rst          (rst),
    .multi_ex     (ex_multi),
    .op_active_ex (op_active_ex)
  );

  rv_hazard u_hazard (
    .rs1_id                (id_rs1),
    .rs2_id                (id_rs2),
    .rs1_used_id           (id_rs1_used),
    .rs2_used_id           (id_rs2_used),
    .rd_ex                 (ex_rd),
    .reg_write_ex          (ex_reg_write),
    .res_src_ex            (ex_res_src),
    .op_active_ex          (op_active_ex),
    .rd_mem                (mem_rd),
    .reg_write_mem         (mem_reg_write),
    .res_src_mem           (mem_res_src),
    .rd_wb                 (wb_rd),
    .reg_write_wb          (wb_reg_write),
    .pc_sel                (pc_sel),
    .mispredicted_ex       (mispredicted_ex),
    .jalr_mispredicted_mem (jalr_mispredicted_mem),
    .btb_pred_taken        (btb_pred_taken),
    .ras_pred_taken        (ras_pred_taken),
    .pc_stall              (pc_stall),
    .if_id_stall           (if_id_stall),
    .if_id_flush           (if_id_flush),
    .id_ex_stall           (id_ex_stall),
    .id_ex_flush           (id_ex_flush),
    .ex_mem_stall          (ex_mem_stall),
    .mem_wb_stall          (mem_wb_stall)
  );

endmodule

//--- tb_rv_pipe_ctrl.sv
`timescale 1ns/10ps

`include "rv_pipe_defs.svh"

// Directed testbench for the pipeline control subsystem
// The initial block plays the fetch and decode side of the core and runs one task per behavior
module tb_rv_pipe_ctrl;

  // Upper bound for every wait loop, in clock cycles
  localparam int WAIT_LIMIT = 50;

  logic                   clk;
  logic                   rst;
  rv_pipe_pkg::reg_addr_t id_rs1;
  rv_pipe_pkg::reg_addr_t id_rs2;
  rv_pipe_pkg::reg_addr_t id_rd;
  logic                   id_rs1_used;
  logic                   id_rs2_used;
  logic                   id_reg_write;
  rv_pipe_pkg::res_src_t  id_res_src;
  logic                   id_multi;
  rv_pipe_pkg::pc_sel_t   pc_sel;
  logic                   mispredicted_ex;
  logic                   jalr_mispredicted_mem;
  logic                   btb_pred_taken;
  logic                   ras_pred_taken;
  logic                   pc_stall;
  logic                   if_id_stall;
  logic                   if_id_flush;
  logic                   id_ex_stall;
  logic                   id_ex_flush;
  logic                   ex_mem_stall;
  logic                   mem_wb_stall;
  rv_pipe_pkg::reg_addr_t wb_rd;
  logic                   wb_reg_write;

  int err_count;
  int check_count;

  // Each instruction that enters WB is logged once and held copies during a freeze are skipped
  logic                   wb_stalled_prev;
  logic                   wb_we_log[$];
  rv_pipe_pkg::reg_addr_t wb_rd_log[$];

  rv_pipe_ctrl rv_pipe_ctrl_inst (
    .clk                   (clk),
    .rst                   (rst),
    .id_rs1                (id_rs1),
    .id_rs2                (id_rs2),
    .id_rd                 (id_rd),
    .id_rs1_used           (id_rs1_used),
    .id_rs2_used           (id_rs2_used),
    .id_reg_write          (id_reg_write),
    .id_res_src            (id_res_src),
    .id_multi              (id_multi),
    .pc_sel                (pc_sel),
    .mispredicted_ex       (mispredicted_ex),
    .jalr_mispredicted_mem (jalr_mispredicted_mem),
    .btb_pred_taken        (btb_pred_taken),
    .ras_pred_taken        (ras_pred_taken),
    .pc_stall              (pc_stall),
    .if_id_stall           (if_id_stall),
    .if_id_flush           (if_id_flush),
    .id_ex_stall           (id_ex_stall),
    .id_ex_flush           (id_ex_flush),
    .ex_mem_stall          (ex_mem_stall),
    .mem_wb_stall          (mem_wb_stall),
    .wb_rd                 (wb_rd),
    .wb_reg_write          (wb_reg_write)
  );

  always #20 clk = ~clk;

  // Values seen at the edge are those of the cycle that just ended
  always @(posedge clk) begin
    if (rst) begin
      wb_stalled_prev = 1'b0;
    end else begin
      if (!wb_stalled_prev) begin
        wb_we_log.push_back(wb_reg_write);
        wb_rd_log.push_back(wb_rd);
      end
      wb_stalled_prev = mem_wb_stall;
    end
  end

  task automatic check_bit(input string name, input logic actual, input logic expected);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("error at %0t: %s is %b, expected %b", $time, name, actual, expected);
    end
  endtask

  task automatic check_reg(input string name, input rv_pipe_pkg::reg_addr_t actual,
                           input rv_pipe_pkg::reg_addr_t expected);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("error at %0t: %s is x%0d, expected x%0d", $time, name, actual, expected);
    end
  endtask

  task automatic check_cycles(input string name, input int actual, input int expected);
    check_count++;
    if (actual != expected) begin
      err_count++;
      $display("error at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  // Bit 0 of used marks rs1 as read, bit 1 marks rs2
  task automatic put_instr(input rv_pipe_pkg::reg_addr_t rs1, input rv_pipe_pkg::reg_addr_t rs2,
                           input logic [1:0] used, input rv_pipe_pkg::reg_addr_t rd,
                           input logic we, input rv_pipe_pkg::res_src_t src, input logic multi);
    id_rs1       <= rs1;
    id_rs2       <= rs2;
    id_rs1_used  <= used[0];
    id_rs2_used  <= used[1];
    id_rd        <= rd;
    id_reg_write <= we;
    id_res_src   <= src;
    id_multi     <= multi;
  endtask

  task automatic put_ctrl(input rv_pipe_pkg::pc_sel_t sel, input logic mis, input logic jalr,
                          input logic btb, input logic ras);
    pc_sel                <= sel;
    mispredicted_ex       <= mis;
    jalr_mispredicted_mem <= jalr;
    btb_pred_taken        <= btb;
    ras_pred_taken        <= ras;
  endtask

  // Presents one instruction in ID and holds it for as long as the front end is stalled
  // Returns the stalled cycles, those with an ID/EX bubble and those with the back end frozen
  task automatic issue(input rv_pipe_pkg::reg_addr_t rs1, input rv_pipe_pkg::reg_addr_t rs2,
                       input logic [1:0] used, input rv_pipe_pkg::reg_addr_t rd,
                       input logic we, input rv_pipe_pkg::res_src_t src, input logic multi,
                       output int stalls, output int flushes, output int frozen);
    int guard;
    stalls  = 0;
    flushes = 0;
    frozen  = 0;
    guard   = 0;
    @(posedge clk);
    put_instr(rs1, rs2, used, rd, we, src, multi);
    @(negedge clk);
    while (pc_stall && guard < WAIT_LIMIT) begin
      // ID must hold whenever fetch is held
      check_bit("if_id_stall", if_id_stall, 1'b1);
      stalls++;
      if (id_ex_flush) flushes++;
      if (id_ex_stall && ex_mem_stall && mem_wb_stall) frozen++;
      guard++;
      @(negedge clk);
    end
    if (pc_stall) begin
      err_count++;
      $display("timeout at %0t: the front end stayed stalled for %0d cycles", $time, guard);
    end
  endtask

  task automatic send_bubble();
    int s;
    int f;
    int z;
    issue(5'd0, 5'd0, 2'b00, 5'd0, 1'b0, rv_pipe_pkg::RES_ALU, 1'b0, s, f, z);
  endtask

  // Sends bubbles until the log holds at least n entries
  task automatic wait_log_size(input int n);
    int guard;
    guard = 0;
    while (wb_we_log.size() < n && guard < WAIT_LIMIT) begin
      send_bubble();
      guard++;
    end
    if (wb_we_log.size() < n) begin
      err_count++;
      $display("timeout at %0t: fewer than %0d instructions reached WB", $time, n);
    end
  endtask

  // Returns the next register write in the log from position pos on, skipping bubbles
  task automatic next_wb_write(inout int pos, output rv_pipe_pkg::reg_addr_t rd);
    int guard;
    guard = 0;
    rd    = 5'd0;
    while (guard < WAIT_LIMIT) begin
      while (pos < wb_we_log.size() && !wb_we_log[pos]) pos++;
      if (pos < wb_we_log.size()) break;
      send_bubble();
      guard++;
    end
    if (pos < wb_we_log.size()) begin
      rd = wb_rd_log[pos];
      pos++;
    end else begin
      err_count++;
      $display("timeout at %0t: no register write reached WB", $time);
    end
  endtask

  task automatic reset_outputs_low();
    check_bit("pc_stall", pc_stall, 1'b0);
    check_bit("if_id_stall", if_id_stall, 1'b0);
    check_bit("if_id_flush", if_id_flush, 1'b0);
    check_bit("id_ex_stall", id_ex_stall, 1'b0);
    check_bit("id_ex_flush", id_ex_flush, 1'b0);
    check_bit("ex_mem_stall", ex_mem_stall, 1'b0);
    check_bit("mem_wb_stall", mem_wb_stall, 1'b0);
    check_bit("wb_reg_write", wb_reg_write, 1'b0);
  endtask

  // Writers x1 to x4, with a load-use pair that puts two bubbles in front of x4
  task automatic writeback_order();
    logic                   exp_we[5];
    rv_pipe_pkg::reg_addr_t exp_rd[5];
    rv_pipe_pkg::reg_addr_t rd;
    int                     pos;
    int                     s;
    int                     f;
    int                     z;
    exp_we = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
    exp_rd = '{5'd2, 5'd3, 5'd0, 5'd0, 5'd4};
    pos = wb_we_log.size();
    issue(5'd0, 5'd0, 2'b00, 5'd1, 1'b1, rv_pipe_pkg::RES_ALU, 1'b0, s, f, z);
    issue(5'd0, 5'd0, 2'b00, 5'd2, 1'b1, rv_pipe_pkg::RES_ALU, 1'b0, s, f, z);
    issue(5'd0, 5'd0, 2'b00, 5'd3, 1'b1, rv_pipe_pkg::RES_LOAD, 1'b0, s, f, z);
    issue(5'd3, 5'd0, 2'b01, 5'd4, 1'b1, rv_pipe_pkg::RES_ALU, 1'b0, s, f, z);
    next_wb_write(pos, rd);
    check_reg("wb_rd", rd, 5'd1);
    wait_log_size(pos + 5);
    for (int i = 0; i < 5; i++) begin
      if (pos + i < wb_we_log.size()) begin
        check_bit("wb_reg_write", wb_we_log[pos + i], exp_we[i]);
        check_reg("wb_rd", wb_rd_log[pos + i], exp_rd[i]);
      end
    end
  endtask

  task automatic load_use_stalls();
    int s;
    int f;
    int z;
    // ALU results are forwarded, so the consumer goes straight on
    issue(5'd0, 5'd0, 2'b00, 5'd5, 1'b1, rv_pipe_pkg::RES_ALU, 1'b0, s, f, z);
    issue(5'd5, 5'd0, 2'b01, 5'd10, 1'b1, rv_pipe_pkg::RES_ALU, 1'b0, s, f, z);
    check_cycles("pc_stall cycles after ALU", s, 0);
    // BRAM load data is late in EX and in MEM and is read through rs2 this time
    issue(5'd0, 5'd0, 2'b00, 5'd6, 1'b1, rv_pipe_pkg::RES_LOAD, 1'b0, s, f, z);
    issue(5'd0, 5'd6, 2'b10, 5'd11, 1'b1, rv_pipe_pkg::RES_ALU, 1'b0, s, f, z);
    check_cycles("pc_stall cycles after load", s, 2);
    check_cycles("id_ex_flush cycles after load", f, 2);
    check_cycles("frozen cycles after load", z, 0);
    // A load to x0 writes nothing, so reading x0 never waits
    issue(5'd0, 5'd0, 2'b00, 5'd0, 1'b1, rv_pipe_pkg::RES_LOAD, 1'b0, s, f, z);
    issue(5'd0, 5'd0, 2'b11, 5'd12, 1'b1, rv_pipe_pkg::RES_ALU, 1'b0, s, f, z);
    check_cycles("pc_stall cycles after x0 load", s, 0);
  endtask

  // Case 0 is a PC redirect, 1 an EX misprediction, 2 a JALR misprediction in MEM
  task automatic redirect_flushes();
    int s;
    int f;
    int z;
    for (int k = 0; k < 3; k++) begin
      issue(5'd0, 5'd0, 2'b00, 5'd5, 1'b1, rv_pipe_pkg::RES_LOAD, 1'b0, s, f, z);
      @(posedge clk);
      put_instr(5'd5, 5'd0, 2'b01, 5'd13, 1'b1, rv_pipe_pkg::RES_ALU, 1'b0);
      put_ctrl((k == 0) ? rv_pipe_pkg::PC_SEL_REDIRECT : rv_pipe_pkg::PC_SEL_SEQ,
               k == 1, k == 2, 1'b0, 1'b0);
      @(negedge clk);
      check_bit("if_id_flush", if_id_flush, 1'b1);
      check_bit("id_ex_flush", id_ex_flush, 1'b1);
      check_bit("pc_stall", pc_stall, 1'b0);
      check_bit("if_id_stall", if_id_stall, 1'b0);
      @(posedge clk);
      put_ctrl(rv_pipe_pkg::PC_SEL_SEQ, 1'b0, 1'b0, 1'b0, 1'b0);
      put_instr(5'd0, 5'd0, 2'b00, 5'd0, 1'b0, rv_pipe_pkg::RES_ALU, 1'b0);
      @(negedge clk);
    end
  endtask

  task automatic predict_once(input logic btb, input logic ras, input logic exp_flush);
    @(posedge clk);
    put_ctrl(rv_pipe_pkg::PC_SEL_PREDICTED, 1'b0, 1'b0, btb, ras);
    put_instr(5'd0, 5'd0, 2'b00, 5'd0, 1'b0, rv_pipe_pkg::RES_ALU, 1'b0);
    @(negedge clk);
    check_bit("if_id_flush", if_id_flush, exp_flush);
    check_bit("pc_stall", pc_stall, 1'b0);
    @(posedge clk);
    put_ctrl(rv_pipe_pkg::PC_SEL_SEQ, 1'b0, 1'b0, 1'b0, 1'b0);
    @(negedge clk);
  endtask

  task automatic prediction_flushes();
    int s;
    int f;
    int z;
    int guard;
    predict_once(1'b1, 1'b0, 1'b0);
    predict_once(1'b0, 1'b1, 1'b1);
    predict_once(1'b0, 1'b0, 1'b1);
    // While ID waits on a load the prediction must not discard it
    issue(5'd0, 5'd0, 2'b00, 5'd9, 1'b1, rv_pipe_pkg::RES_LOAD, 1'b0, s, f, z);
    @(posedge clk);
    put_instr(5'd9, 5'd0, 2'b01, 5'd14, 1'b1, rv_pipe_pkg::RES_ALU, 1'b0);
    put_ctrl(rv_pipe_pkg::PC_SEL_PREDICTED, 1'b0, 1'b0, 1'b0, 1'b1);
    @(negedge clk);
    check_bit("if_id_flush", if_id_flush, 1'b0);
    check_bit("pc_stall", pc_stall, 1'b1);
    check_bit("id_ex_flush", id_ex_flush, 1'b1);
    @(posedge clk);
    put_ctrl(rv_pipe_pkg::PC_SEL_SEQ, 1'b0, 1'b0, 1'b0, 1'b0);
    @(negedge clk);
    // The consumer stays in ID until the load has left MEM
    guard = 0;
    while (pc_stall && guard < WAIT_LIMIT) begin
      guard++;
      @(negedge clk);
    end
    if (pc_stall) begin
      err_count++;
      $display("timeout at %0t: the front end stayed stalled for %0d cycles", $time, guard);
    end
  endtask

  // A divide to x7 followed by an independent writer to x8
  task automatic multi_cycle_freeze();
    rv_pipe_pkg::reg_addr_t rd;
    int                     pos;
    int                     s;
    int                     f;
    int                     z;
    // Older writers retire and get logged before the log position is taken
    repeat (4) send_bubble();
    pos = wb_we_log.size();
    issue(5'd0, 5'd0, 2'b00, 5'd7, 1'b1, rv_pipe_pkg::RES_M, 1'b1, s, f, z);
    check_cycles("pc_stall cycles before the divide", s, 0);
    issue(5'd1, 5'd0, 2'b01, 5'd8, 1'b1, rv_pipe_pkg::RES_ALU, 1'b0, s, f, z);
    check_cycles("pc_stall cycles behind the divide", s, `RV_MDU_CYCLES);
    check_cycles("frozen cycles behind the divide", z, `RV_MDU_CYCLES);
    check_cycles("id_ex_flush cycles behind the divide", f, 0);
    next_wb_write(pos, rd);
    check_reg("wb_rd", rd, 5'd7);
    next_wb_write(pos, rd);
    check_reg("wb_rd", rd, 5'd8);
  endtask

  initial begin
    err_count   = 0;
    check_count = 0;
    clk         = 1'b0;
    rst         = 1'b1;
    put_instr(5'd0, 5'd0, 2'b00, 5'd0, 1'b0, rv_pipe_pkg::RES_ALU, 1'b0);
    put_ctrl(rv_pipe_pkg::PC_SEL_SEQ, 1'b0, 1'b0, 1'b0, 1'b0);
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    reset_outputs_low();
    writeback_order();
    load_use_stalls();
    redirect_flushes();
    prediction_flushes();
    multi_cycle_freeze();
    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+.
rv_pipe_pkg.sv
rv_ctrl_stage.sv
rv_mdu_seq.sv
rv_hazard.sv
rv_pipe_ctrl.sv
tb_rv_pipe_ctrl.sv

//--- Makefile
# Verilator build and run for the pipeline control subsystem

TOP := tb_rv_pipe_ctrl

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): files.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
